//--- spw_char_pkg.sv
// SpaceWire character definitions
// Character kinds, control codes, character lengths
// and the token passed from decode to execute

`default_nettype none

package spw_char_pkg;

	// Word widths
	localparam int N_CHAR_W = 9;
	localparam int DATA_W = 8;

	// Kinds of character the transmitter can send
	typedef enum logic [2:0] {
		NULL = 3'd0,
		FCT  = 3'd1,
		DATA = 3'd2,
		EOP  = 3'd3,
		EEP  = 3'd4
	} char_kind_t;

	// Control codes, bit 1 goes on the line first
	localparam logic [1:0] CODE_FCT = 2'b00;
	localparam logic [1:0] CODE_EOP = 2'b01;
	localparam logic [1:0] CODE_EEP = 2'b10;
	localparam logic [1:0] CODE_ESC = 2'b11;

	// Character lengths in bits, parity included
	localparam int NULL_LEN = 8;
	localparam int DATA_LEN = 10;
	localparam int CTRL_LEN = 4;

	typedef struct packed {
		char_kind_t kind;
		logic [DATA_W-1:0] data;
	} tx_token_t;

endpackage

`default_nettype wire

//--- spw_tx_pkg.sv
// SpaceWire transmitter definitions
// Link states, credit defaults and the bit passed
// from execute to result

`default_nettype none

package spw_tx_pkg;

	// Link-up sequence
	typedef enum logic [1:0] {
		START     = 2'd0,
		NULL_ONLY = 2'd1,
		NULL_FCT  = 2'd2,
		RUN       = 2'd3
	} link_state_t;

	// --------------------
	// Flow control
	// --------------------

	// Credit counter range and step per received FCT
	localparam int CREDIT_MAX_DEF = 56;
	localparam int CREDIT_PER_FCT = 8;
	localparam int CREDIT_W = 6;

	// FCTs owed to the far end, also the start value
	localparam int FCT_OWED_MAX_DEF = 7;

	// One line bit with its qualifier
	typedef struct packed {
		logic valid;
		logic data;
	} line_bit_t;

endpackage

`default_nettype wire

//--- spw_tx_credit.sv
// Transmit flow control counters
// Credit received from the far end and FCTs owed to it

`timescale 1ns/10ps
`default_nettype none

module spw_tx_credit #(
	parameter int CREDIT_MAX = spw_tx_pkg::CREDIT_MAX_DEF,
	parameter int FCT_OWED_MAX = spw_tx_pkg::FCT_OWED_MAX_DEF
) (
	input  logic pclk_tx,
	input  logic rst_i,
	input  logic enable_i,
	input  logic gotfct_i,
	input  logic fct_request_i,
	input  logic nchar_sent_i,
	input  logic fct_sent_i,
	output logic has_credit_o,
	output logic fct_owed_nz_o
);
	import spw_tx_pkg::*;

	localparam int OWED_W = $clog2(FCT_OWED_MAX + 1);

	logic [CREDIT_W-1:0] credit;
	logic [CREDIT_W:0] credit_sum;
	logic credit_add;
	logic [OWED_W-1:0] fct_owed;
	logic [OWED_W:0] owed_next;

	// A received FCT is dropped if it would overflow the range
	assign credit_sum = {1'b0, credit} + (CREDIT_W+1)'(CREDIT_PER_FCT);
	assign credit_add = gotfct_i && (credit_sum <= (CREDIT_W+1)'(CREDIT_MAX));

	// Send and request may land in the same cycle
	always_comb
	begin
		owed_next = {1'b0, fct_owed};
		if (fct_sent_i && fct_owed != '0)
			owed_next = owed_next - 1'b1;
		if (fct_request_i && owed_next < (OWED_W+1)'(FCT_OWED_MAX))
			owed_next = owed_next + 1'b1;
	end

	always_ff @(posedge pclk_tx)
	begin
		if (rst_i || !enable_i)
		begin
			credit <= '0;
			fct_owed <= OWED_W'(FCT_OWED_MAX);
		end
		else
		begin
			if (credit_add && nchar_sent_i)
				credit <= credit_sum[CREDIT_W-1:0] - 1'b1;
			else if (credit_add)
				credit <= credit_sum[CREDIT_W-1:0];
			else if (nchar_sent_i && credit != '0)
				credit <= credit - 1'b1;
			fct_owed <= owed_next[OWED_W-1:0];
		end
	end

	assign has_credit_o = (credit != '0);
	assign fct_owed_nz_o = (fct_owed != '0);

endmodule

`default_nettype wire

//--- spw_tx_scheduler.sv
// Decode stage of the transmitter
// Link state machine, N-character decode and choice
// of the next token for the serializer

`timescale 1ns/10ps
`default_nettype none

module spw_tx_scheduler (
	input  logic pclk_tx,
	input  logic rst_i,
	input  logic enable_i,
	input  logic send_null_i,
	input  logic send_fct_i,
	input  logic write_i,
	input  logic [spw_char_pkg::N_CHAR_W-1:0] data_i,
	input  logic next_i,
	input  logic has_credit_i,
	input  logic fct_owed_nz_i,
	output spw_char_pkg::tx_token_t tok_o,
	output logic nchar_sent_o,
	output logic fct_sent_o,
	output logic data_ready_o
);
	import spw_char_pkg::*;
	import spw_tx_pkg::*;

	link_state_t state;
	link_state_t state_nxt;
	char_kind_t nchar_kind;
	logic is_nchar;

	// Flag set means EOP or EEP, bit 0 picks which
	always_comb
	begin
		if (!data_i[N_CHAR_W-1])
			nchar_kind = DATA;
		else if (data_i[0])
			nchar_kind = EEP;
		else
			nchar_kind = EOP;
	end

	// --------------------
	// Token choice
	// --------------------
	always_comb
	begin
		tok_o.kind = NULL;
		tok_o.data = '0;
		case (state)
			NULL_FCT:
			begin
				if (fct_owed_nz_i)
					tok_o.kind = FCT;
			end
			RUN:
			begin
				if (fct_owed_nz_i)
				begin
					tok_o.kind = FCT;
				end
				else if (write_i && has_credit_i)
				begin
					tok_o.kind = nchar_kind;
					tok_o.data = data_i[DATA_W-1:0];
				end
			end
			default:
			begin
				tok_o.kind = NULL;
			end
		endcase
	end

	assign is_nchar = (tok_o.kind == DATA) || (tok_o.kind == EOP) || (tok_o.kind == EEP);
	assign nchar_sent_o = next_i && is_nchar;
	assign fct_sent_o = next_i && (tok_o.kind == FCT);

	// --------------------
	// Link state machine
	// --------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			START:     if (send_null_i) state_nxt = NULL_ONLY;
			NULL_ONLY: if (send_fct_i) state_nxt = NULL_FCT;
			NULL_FCT:  if (has_credit_i) state_nxt = RUN;
			default:   state_nxt = RUN;
		endcase
	end

	// State moves only when the serializer takes a token
	always_ff @(posedge pclk_tx)
	begin
		if (rst_i || !enable_i)
		begin
			state <= START;
			data_ready_o <= 1'b0;
		end
		else
		begin
			if (next_i)
				state <= state_nxt;
			data_ready_o <= nchar_sent_o;
		end
	end

endmodule

`default_nettype wire

//--- spw_char_serializer.sv
// Execute stage of the transmitter
// Latches tokens, builds each character with its parity
// and shifts it out one bit per clock

`timescale 1ns/10ps
`default_nettype none

module spw_char_serializer (
	input  logic pclk_tx,
	input  logic rst_i,
	input  logic enable_i,
	input  spw_char_pkg::tx_token_t tok_i,
	output logic next_o,
	output spw_tx_pkg::line_bit_t bit_o
);
	import spw_char_pkg::*;

	tx_token_t tok_q;
	logic busy;
	logic [3:0] bit_cnt;
	logic [3:0] last_idx;
	logic last_par;
	logic flag;
	logic par_bit;
	logic [DATA_LEN-1:0] frame;

	function automatic logic [3:0] char_len(input char_kind_t kind);
		case (kind)
			NULL:    return 4'(NULL_LEN);
			DATA:    return 4'(DATA_LEN);
			default: return 4'(CTRL_LEN);
		endcase
	endfunction

	// Parity of the bits after the flag; a NULL ends with its FCT part
	function automatic logic payload_par(input tx_token_t t);
		case (t.kind)
			DATA:    return ^t.data;
			EOP:     return ^CODE_EOP;
			EEP:     return ^CODE_EEP;
			default: return ^CODE_FCT;
		endcase
	endfunction

	// Character bits in line order, bit k goes out at count k
	function automatic logic [DATA_LEN-1:0] char_frame(input tx_token_t t, input logic p);
		logic inner_par;
		logic [DATA_LEN-1:0] f;
		inner_par = ~(1'b1 ^ (^CODE_ESC));
		case (t.kind)
			DATA: f = {t.data, 1'b0, p};
			EOP:  f = {6'b0, CODE_EOP[0], CODE_EOP[1], 1'b1, p};
			EEP:  f = {6'b0, CODE_EEP[0], CODE_EEP[1], 1'b1, p};
			FCT:  f = {6'b0, CODE_FCT[0], CODE_FCT[1], 1'b1, p};
			default:
			begin
				f = {2'b0, CODE_FCT[0], CODE_FCT[1], 1'b1, inner_par,
					CODE_ESC[0], CODE_ESC[1], 1'b1, p};
			end
		endcase
		return f;
	endfunction

	// --------------------
	// Parity and framing
	// --------------------
	assign flag = (tok_q.kind != DATA);
	assign par_bit = ~(flag ^ last_par);
	assign frame = char_frame(tok_q, par_bit);
	assign last_idx = char_len(tok_q.kind) - 4'd1;

	// Take a new token on the last bit, or straight away when idle
	assign next_o = busy ? (bit_cnt == last_idx) : enable_i;

	assign bit_o.valid = busy;
	assign bit_o.data = busy && frame[bit_cnt];

	// last_par starts at 0 so the first NULL has parity 0
	always_ff @(posedge pclk_tx)
	begin
		if (rst_i || !enable_i)
		begin
			busy <= 1'b0;
			bit_cnt <= '0;
			last_par <= 1'b0;
		end
		else if (next_o)
		begin
			if (busy)
				last_par <= payload_par(tok_q);
			busy <= 1'b1;
			bit_cnt <= '0;
		end
		else
		begin
			bit_cnt <= bit_cnt + 4'd1;
		end
	end

	always_ff @(posedge pclk_tx)
	begin
		if (next_o)
			tok_q <= tok_i;
	end

endmodule

`default_nettype wire

//--- spw_ds_encoder.sv
// Result stage of the transmitter
// Data-strobe line encoding with registered outputs

`timescale 1ns/10ps
`default_nettype none

module spw_ds_encoder (
	input  logic pclk_tx,
	input  logic rst_i,
	input  logic enable_i,
	input  spw_tx_pkg::line_bit_t bit_i,
	output logic dout_o,
	output logic sout_o
);

	// Strobe flips when data repeats, so one line moves per bit
	always_ff @(posedge pclk_tx)
	begin
		if (rst_i || !enable_i)
		begin
			dout_o <= 1'b0;
			sout_o <= 1'b0;
		end
		else if (bit_i.valid)
		begin
			dout_o <= bit_i.data;
			if (bit_i.data == dout_o)
				sout_o <= ~sout_o;
		end
	end

endmodule

`default_nettype wire

//--- spw_tx_top.sv
// SpaceWire transmitter top level
// Flow control counters, decode, execute and line encoder

`timescale 1ns/10ps
`default_nettype none

module spw_tx_top #(
	parameter int CREDIT_MAX = spw_tx_pkg::CREDIT_MAX_DEF,
	parameter int FCT_OWED_MAX = spw_tx_pkg::FCT_OWED_MAX_DEF
) (
	input  logic pclk_tx,
	input  logic rst_i,
	input  logic enable_i,
	input  logic send_null_i,
	input  logic send_fct_i,
	input  logic [spw_char_pkg::N_CHAR_W-1:0] data_i,
	input  logic write_i,
	input  logic gotfct_i,
	input  logic fct_request_i,
	output logic dout_o,
	output logic sout_o,
	output logic data_ready_o
);
	import spw_char_pkg::*;
	import spw_tx_pkg::*;

	tx_token_t tok;
	line_bit_t line_bit;
	logic next;
	logic nchar_sent;
	logic fct_sent;
	logic has_credit;
	logic fct_owed_nz;

	spw_tx_credit #(
		.CREDIT_MAX(CREDIT_MAX),
		.FCT_OWED_MAX(FCT_OWED_MAX)
	) u_credit (
		.pclk_tx(pclk_tx),
		.rst_i(rst_i),
		.enable_i(enable_i),
		.gotfct_i(gotfct_i),
		.fct_request_i(fct_request_i),
		.nchar_sent_i(nchar_sent),
		.fct_sent_i(fct_sent),
		.has_credit_o(has_credit),
		.fct_owed_nz_o(fct_owed_nz)
	);

	spw_tx_scheduler u_scheduler (
		.pclk_tx(pclk_tx),
		.rst_i(rst_i),
		.enable_i(enable_i),
		.send_null_i(send_null_i),
		.send_fct_i(send_fct_i),
		.write_i(write_i),
		.data_i(data_i),
		.next_i(next),
		.has_credit_i(has_credit),
		.fct_owed_nz_i(fct_owed_nz),
		.tok_o(tok),
		.nchar_sent_o(nchar_sent),
		.fct_sent_o(fct_sent),
		.data_ready_o(data_ready_o)
	);

	spw_char_serializer u_serializer (
		.pclk_tx(pclk_tx),
		.rst_i(rst_i),
		.enable_i(enable_i),
		.tok_i(tok),
		.next_o(next),
		.bit_o(line_bit)
	);

	spw_ds_encoder u_encoder (
		.pclk_tx(pclk_tx),
		.rst_i(rst_i),
		.enable_i(enable_i),
		.bit_i(line_bit),
		.dout_o(dout_o),
		.sout_o(sout_o)
	);

endmodule

`default_nettype wire

//--- tb_spw_tx_top.sv
// Testbench for the SpaceWire transmitter
// Clock, stimulus, a data-strobe line decoder,
// character checks and the closing report

`timescale 1ns/10ps
`default_nettype none

module tb_spw_tx_top;
	import spw_char_pkg::*;

	localparam int CYCLE_LIMIT = 3000;
	localparam int N_WORDS = 16;
	localparam int INIT_FCTS = 7;
	localparam int NCHARS_PER_FCT = 8;

	logic pclk_tx, rst_i, enable_i, send_null_i, send_fct_i;
	logic write_i, gotfct_i, fct_request_i;
	logic [N_CHAR_W-1:0] data_i;
	logic dout_o, sout_o, data_ready_o;

	int errors = 0;
	int cycles = 0;
	int word_idx = 0;
	int fct_before = 0;
	int n_chars = 0;
	int n_null = 0;
	int n_fct = 0;
	int n_nchar = 0;
	int n_ready = 0;
	logic [N_CHAR_W-1:0] words [N_WORDS];
	logic bits[$];
	logic started = 1'b0;
	logic clr_prev = 1'b1;
	logic prev_d = 1'b0;
	logic prev_s = 1'b0;
	logic prev_par = 1'b0;
	logic ready_seen = 1'b0;
	logic feed_on = 1'b0;

	spw_tx_top uut (.*);

	always #5 pclk_tx = ~pclk_tx;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic flag_error(input string msg);
		errors++;
		$display("FAILED %0t: %s", $time, msg);
	endtask

	task automatic wait_chars(input int n);
		int target;
		target = n_chars + n;
		while (n_chars < target)
			@(posedge pclk_tx);
	endtask

	task automatic pulse_fct_inputs(input logic got, input logic req);
		gotfct_i <= got;
		fct_request_i <= req;
		@(posedge pclk_tx);
		gotfct_i <= 1'b0;
		fct_request_i <= 1'b0;
	endtask

	// --------------------
	// Line decoder
	// --------------------

	// Decode a complete character from the collected bits
	task automatic parse_bits();
		tx_token_t c;
		logic [N_CHAR_W-1:0] w;
		int len;
		int pay_lo;
		c = '0;
		len = 0;
		pay_lo = 2;
		if (bits.size() == DATA_LEN && !bits[1])
		begin
			len = DATA_LEN;
			c.kind = DATA;
			for (int i = 0; i < DATA_W; i++)
				c.data[i] = bits[i + 2];
		end
		else if (bits.size() == CTRL_LEN && bits[1] && {bits[2], bits[3]} != CODE_ESC)
		begin
			len = CTRL_LEN;
			c.kind = ({bits[2], bits[3]} == CODE_FCT) ? FCT :
				({bits[2], bits[3]} == CODE_EOP) ? EOP : EEP;
		end
		else if (bits.size() == NULL_LEN && bits[1])
		begin
			len = NULL_LEN;
			pay_lo = 6;
			// ESC then the FCT half with its own parity bit
			assert (bits[5] && {bits[6], bits[7]} == CODE_FCT
				&& bits[4] == !(bits[5] ^ bits[2] ^ bits[3]))
			else flag_error("malformed NULL on the line");
		end
		if (len == 0)
			return;
		if (n_chars == 0)
		begin
			assert (bits[0] == 1'b0) else flag_error("first parity bit is not 0");
		end
		assert (bits[0] == !(prev_par ^ bits[1]))
		else flag_error($sformatf("parity error on character %0d", n_chars));
		prev_par = 1'b0;
		for (int i = pay_lo; i < len; i++)
			prev_par = prev_par ^ bits[i];
		bits.delete();
		n_chars++;
		if (c.kind == NULL)
			n_null++;
		else if (c.kind == FCT)
			n_fct++;
		else
		begin
			w = (c.kind == DATA) ? {1'b0, c.data} : {1'b1, 7'b0, c.kind == EEP};
			if (n_nchar == 0)
			begin
				assert (n_fct == INIT_FCTS) else flag_error("wrong FCT count before N-characters");
			end
			assert (n_nchar < N_WORDS && w == words[n_nchar])
			else flag_error($sformatf("N-character %0d is %h, expected %h",
				n_nchar, w, words[n_nchar]));
			n_nchar++;
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge pclk_tx)
	begin
		if (clr_prev)
		begin
			assert (!dout_o && !sout_o && !data_ready_o)
			else flag_error("line or ready output not low during reset or disable");
			started = 1'b0;
			prev_par = 1'b0;
			bits.delete();
		end
		else
		begin
			if (started)
			begin
				assert ((dout_o ^ sout_o) != (prev_d ^ prev_s))
				else flag_error("no line transition in a bit period");
			end
			else if (dout_o != prev_d || sout_o != prev_s)
				started = 1'b1;
			if (started)
			begin
				bits.push_back(dout_o);
				parse_bits();
			end
			if (data_ready_o)
			begin
				n_ready++;
				ready_seen = 1'b1;
			end
		end
		prev_d = dout_o;
		prev_s = sout_o;
		clr_prev = rst_i || !enable_i;
	end

	// Next data word on the edge after a ready pulse
	always @(posedge pclk_tx)
	begin
		if (ready_seen)
		begin
			ready_seen <= 1'b0;
			word_idx++;
		end
		write_i <= feed_on && word_idx < N_WORDS;
		data_i <= (word_idx < N_WORDS) ? words[word_idx] : '0;
	end

	always @(posedge pclk_tx)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// --------------------
	// Test phases
	// --------------------
	initial
	begin
		logic [31:0] seed;
		pclk_tx = 1'b0;
		rst_i = 1'b1;
		enable_i = 1'b1;
		send_null_i = 1'b0;
		send_fct_i = 1'b0;
		write_i = 1'b0;
		data_i = '0;
		gotfct_i = 1'b0;
		fct_request_i = 1'b0;
		// EOP and EEP take turns in every fourth slot
		seed = 32'd17;
		for (int i = 0; i < N_WORDS; i++)
		begin
			seed = xorshift32(seed);
			words[i] = (i % 4 == 3) ? {1'b1, 7'b0, 1'(i / 4 % 2)} : {1'b0, seed[7:0]};
		end
		repeat (16) @(posedge pclk_tx);
		rst_i <= 1'b0;
		send_null_i <= 1'b1;
		wait_chars(4);
		assert (n_null == n_chars) else flag_error("non-NULL character before send_fct");
		send_fct_i <= 1'b1;
		while (n_fct < INIT_FCTS)
			@(posedge pclk_tx);
		wait_chars(3);
		assert (n_fct == INIT_FCTS) else flag_error("wrong number of initial FCTs");
		// Words waiting without credit
		feed_on <= 1'b1;
		wait_chars(5);
		assert (n_nchar == 0 && n_ready == 0) else flag_error("N-character sent without credit");
		pulse_fct_inputs(1'b1, 1'b0);
		while (n_nchar < NCHARS_PER_FCT)
			@(posedge pclk_tx);
		wait_chars(6);
		assert (n_nchar == NCHARS_PER_FCT && n_ready == NCHARS_PER_FCT)
		else flag_error("wrong N-character or ready count for one FCT");
		repeat (2)
		begin
			fct_before = n_fct;
			pulse_fct_inputs(1'b0, 1'b1);
			wait_chars(4);
			assert (n_fct == fct_before + 1) else flag_error("FCT request not met by one FCT");
		end
		pulse_fct_inputs(1'b1, 1'b0);
		while (n_nchar < N_WORDS)
			@(posedge pclk_tx);
		wait_chars(4);
		assert (n_nchar == N_WORDS && n_ready == N_WORDS && word_idx == N_WORDS)
		else flag_error("data port and sent N-characters disagree");
		enable_i <= 1'b0;
		send_null_i <= 1'b0;
		send_fct_i <= 1'b0;
		repeat (4) @(posedge pclk_tx);
		$display("Errors %0d, NULL %0d, FCT %0d, N-char %0d, ready pulses %0d",
			errors, n_null, n_fct, n_nchar, n_ready);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- spw_tx_top.f
spw_char_pkg.sv
spw_tx_pkg.sv
spw_tx_credit.sv
spw_tx_scheduler.sv
spw_char_serializer.sv
spw_ds_encoder.sv
spw_tx_top.sv
tb_spw_tx_top.sv
